// ==== Bender.yml ====
package:
  name: iodelay_lane_ctrl

sources:
  - files:
      - rtl/iodelay_fsm_pkg.sv
      - rtl/iodelay_types_pkg.sv
      - rtl/iodelay_seq_fsm.sv
      - rtl/iodelay_step_engine.sv
      - rtl/iodelay_lane_ctrl.sv
  - target: test
    files:
      - verification/iodelay_lane_ctrl_assertions.sv
      - verification/tb_iodelay_lane_ctrl.sv

// ==== iodelay_lane_ctrl.f ====
rtl/iodelay_fsm_pkg.sv
rtl/iodelay_types_pkg.sv
rtl/iodelay_seq_fsm.sv
rtl/iodelay_step_engine.sv
rtl/iodelay_lane_ctrl.sv
verification/iodelay_lane_ctrl_assertions.sv
verification/tb_iodelay_lane_ctrl.sv

// ==== rtl/iodelay_fsm_pkg.sv ====
package iodelay_fsm_pkg;

    // host command codes, bits [14:12] of the control word
    // codes 4..7 are decoded as a plain read
    typedef enum logic [2:0]
    {
        CMD_READ   = 3'd0,
        CMD_INC    = 3'd1,
        CMD_DEC    = 3'd2,
        CMD_UPDATE = 3'd3
    } cmd_e;

    // sequencer around every command
    typedef enum logic [3:0]
    {
        SEQ_IDLE,
        SEQ_VTC_WAIT,     // wait for vtc ready, then drop en_vtc
        SEQ_SETTLE_IN,
        SEQ_DECODE,
        SEQ_CE_PULSE,     // ce high
        SEQ_CE_HOLD,      // one quiet cycle after ce
        SEQ_UPDATE,       // step engine busy
        SEQ_SETTLE_OUT    // done, register clear, read-back
    } seq_state_e;

    // step engine, one round per step
    typedef enum logic [2:0]
    {
        STEP_IDLE,
        STEP_DIFF,
        STEP_ADDEND,
        STEP_NEWVAL,
        STEP_LOAD,
        STEP_WAIT,
        STEP_ACK
    } step_state_e;

endpackage

// ==== rtl/iodelay_lane_ctrl.sv ====
`timescale 1ns/1ps

module iodelay_lane_ctrl
#(
    parameter int unsigned SETTLE_CYCLES    = 10,
    parameter int unsigned LOAD_WAIT_CYCLES = 5,
    parameter int unsigned MAX_STEP         = 8    // must fit addend_t
)
(
    input  logic                          riu_clk,
    input  logic                          rst_riu,
    input  iodelay_types_pkg::ctrl_reg_t   ctrl_reg_i,
    input  iodelay_types_pkg::delay_t      cntvalue_i,
    input  logic                          vtc_rdy_i,
    output iodelay_types_pkg::delay_t      cntvalue_o,
    output iodelay_types_pkg::dly_strobe_t strobe_o,
    output logic                          en_vtc_o,
    output logic                          rst_ctrl_reg_o,
    output iodelay_types_pkg::status_reg_t status_o
);
    import iodelay_types_pkg::*;

    // sequencer <-> step engine handshake
    logic   step_req;
    logic   step_ack;
    delay_t step_target;
    delay_t step_start;

    logic   load;       // from the step engine
    logic   ce;         // from the sequencer
    logic   inc;
    logic   done;
    logic   modified;
    delay_t readback;

    iodelay_seq_fsm #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_seq (
        .riu_clk        (riu_clk),
        .rst_riu        (rst_riu),
        .trig_i         (ctrl_reg_i.trig),
        .cmd_i          (ctrl_reg_i.cmd),
        .target_i       (ctrl_reg_i.target),
        .cntvalue_i     (cntvalue_i),
        .vtc_rdy_i      (vtc_rdy_i),
        .step_ack_i     (step_ack),
        .step_req_o     (step_req),
        .step_target_o  (step_target),
        .step_start_o   (step_start),
        .ce_o           (ce),
        .inc_o          (inc),
        .en_vtc_o       (en_vtc_o),
        .rst_ctrl_reg_o (rst_ctrl_reg_o),
        .done_o         (done),
        .modified_o     (modified),
        .readback_o     (readback)
    );

    iodelay_step_engine #(
        .LOAD_WAIT_CYCLES (LOAD_WAIT_CYCLES),
        .MAX_STEP         (MAX_STEP)
    ) u_step (
        .riu_clk       (riu_clk),
        .rst_riu       (rst_riu),
        .step_req_i    (step_req),
        .step_target_i (step_target),
        .step_start_i  (step_start),
        .cntvalue_i    (cntvalue_i),
        .step_ack_o    (step_ack),
        .load_o        (load),
        .cntvalue_o    (cntvalue_o)
    );

    //////////////////////////////
    // strobe merge, status word
    //////////////////////////////

    always_comb
    begin
        strobe_o      = '0;
        strobe_o.load = load;
        strobe_o.ce   = ce;
        strobe_o.inc  = inc;
    end

    always_comb
    begin
        status_o          = '0;
        status_o.done     = done;
        status_o.error    = 1'b0;     // no lane error source
        status_o.modified = modified;
        status_o.delay    = readback;
    end

endmodule

// ==== rtl/iodelay_seq_fsm.sv ====
`timescale 1ns/1ps

module iodelay_seq_fsm
#(
    parameter int unsigned SETTLE_CYCLES = 10
)
(
    input  logic                      riu_clk,
    input  logic                      rst_riu,
    input  logic                      trig_i,
    input  iodelay_fsm_pkg::cmd_e      cmd_i,
    input  iodelay_types_pkg::delay_t  target_i,
    input  iodelay_types_pkg::delay_t  cntvalue_i,
    input  logic                      vtc_rdy_i,
    input  logic                      step_ack_i,
    output logic                      step_req_o,
    output iodelay_types_pkg::delay_t  step_target_o,
    output iodelay_types_pkg::delay_t  step_start_o,
    output logic                      ce_o,
    output logic                      inc_o,
    output logic                      en_vtc_o,
    output logic                      rst_ctrl_reg_o,
    output logic                      done_o,
    output logic                      modified_o,
    output iodelay_types_pkg::delay_t  readback_o
);
    import iodelay_types_pkg::*;
    import iodelay_fsm_pkg::*;

    localparam int CNT_W = (SETTLE_CYCLES > 0) ? $clog2(SETTLE_CYCLES + 1) : 1;

    seq_state_e       state;
    logic             trig_d;
    logic             trig_re;      // registered rising edge
    cmd_e             cmd_q;
    delay_t           target_q;
    logic [CNT_W-1:0] cnt;          // shared by both settle waits
    logic             cnt_last;

    assign cnt_last = (cnt == CNT_W'(SETTLE_CYCLES));

    //////////////////////////////
    // trigger edge
    //////////////////////////////

    always_ff @(posedge riu_clk or posedge rst_riu)
    begin
        if (rst_riu)
        begin
            trig_d  <= 1'b0;
            trig_re <= 1'b0;
        end
        else
        begin
            trig_d  <= trig_i;
            trig_re <= trig_i & ~trig_d;
        end
    end

    // target and start value only matter while step_req is high
    always_ff @(posedge riu_clk)
    begin
        if (state == SEQ_IDLE && trig_re)
            target_q <= target_i;
        if (state == SEQ_DECODE)
            step_start_o <= cntvalue_i;
    end

    assign step_target_o  = target_q;
    assign rst_ctrl_reg_o = (state == SEQ_SETTLE_OUT);   // host clears trig meanwhile

    //////////////////////////////
    // sequencer
    //////////////////////////////

    always_ff @(posedge riu_clk or posedge rst_riu)
    begin
        if (rst_riu)
        begin
            state      <= SEQ_IDLE;
            cmd_q      <= CMD_READ;
            cnt        <= '0;
            step_req_o <= 1'b0;
            ce_o       <= 1'b0;
            inc_o      <= 1'b0;
            en_vtc_o   <= 1'b1;
            done_o     <= 1'b0;
            modified_o <= 1'b0;
            readback_o <= '0;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    cnt <= '0;
                    if (trig_re)
                    begin
                        cmd_q <= cmd_i;
                        state <= SEQ_VTC_WAIT;
                    end
                end
                SEQ_VTC_WAIT:
                begin
                    if (vtc_rdy_i)          // no time limit on this stall
                    begin
                        en_vtc_o <= 1'b0;
                        done_o   <= 1'b0;
                        state    <= SEQ_SETTLE_IN;
                    end
                end
                SEQ_SETTLE_IN:
                begin
                    cnt <= cnt_last ? '0 : cnt + 1'b1;
                    if (cnt_last)
                        state <= SEQ_DECODE;
                end
                SEQ_DECODE:
                begin
                    readback_o <= cntvalue_i;
                    case (cmd_q)
                        CMD_INC, CMD_DEC:
                        begin
                            ce_o       <= 1'b1;
                            inc_o      <= (cmd_q == CMD_INC);
                            modified_o <= 1'b1;
                            state      <= SEQ_CE_PULSE;
                        end
                        CMD_UPDATE:
                        begin
                            step_req_o <= 1'b1;
                            modified_o <= 1'b1;
                            state      <= SEQ_UPDATE;
                        end
                        default: state <= SEQ_SETTLE_OUT;   // read and unused codes
                    endcase
                end
                SEQ_CE_PULSE:
                begin
                    ce_o  <= 1'b0;
                    inc_o <= 1'b0;
                    state <= SEQ_CE_HOLD;
                end
                SEQ_CE_HOLD:
                    state <= SEQ_SETTLE_OUT;
                SEQ_UPDATE:
                begin
                    if (step_ack_i)
                    begin
                        step_req_o <= 1'b0;     // engine drops ack after this
                        state      <= SEQ_SETTLE_OUT;
                    end
                end
                SEQ_SETTLE_OUT:
                begin
                    done_o     <= 1'b1;
                    readback_o <= cntvalue_i;   // track the line while settling
                    cnt        <= cnt_last ? '0 : cnt + 1'b1;
                    if (cnt_last)
                    begin
                        en_vtc_o <= 1'b1;
                        state    <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/iodelay_step_engine.sv ====
`timescale 1ns/1ps

module iodelay_step_engine
#(
    parameter int unsigned LOAD_WAIT_CYCLES = 5,
    parameter int unsigned MAX_STEP         = 8
)
(
    input  logic                      riu_clk,
    input  logic                      rst_riu,
    input  logic                      step_req_i,
    input  iodelay_types_pkg::delay_t  step_target_i,
    input  iodelay_types_pkg::delay_t  step_start_i,
    input  iodelay_types_pkg::delay_t  cntvalue_i,
    output logic                      step_ack_o,
    output logic                      load_o,
    output iodelay_types_pkg::delay_t  cntvalue_o
);
    import iodelay_types_pkg::*;
    import iodelay_fsm_pkg::*;

    localparam int WAIT_W = (LOAD_WAIT_CYCLES > 0) ? $clog2(LOAD_WAIT_CYCLES + 1) : 1;

    step_state_e       state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              wait_last;

    delay_t  cur;       // line value at the start of a round
    delay_t  diff;
    logic    dir_up;
    addend_t addend;

    assign wait_last = (wait_cnt == WAIT_W'(LOAD_WAIT_CYCLES));

    //////////////////////////////
    // datapath
    //////////////////////////////

    always_ff @(posedge riu_clk)
    begin
        case (state)
            STEP_IDLE:
                cur <= step_start_i;
            STEP_DIFF:
            begin
                if (step_target_i > cur)
                begin
                    diff   <= step_target_i - cur;
                    dir_up <= 1'b1;
                end
                else
                begin
                    diff   <= cur - step_target_i;   // zero when on target
                    dir_up <= 1'b0;
                end
            end
            STEP_ADDEND:
            begin
                if (diff > delay_t'(MAX_STEP))
                    addend <= addend_t'(MAX_STEP);
                else
                    addend <= addend_t'(diff);
            end
            STEP_NEWVAL:
                cntvalue_o <= dir_up ? cur + delay_t'(addend) : cur - delay_t'(addend);
            STEP_WAIT:
            begin
                if (wait_last)
                    cur <= cntvalue_i;      // re-read after the load
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge riu_clk or posedge rst_riu)
    begin
        if (rst_riu)
        begin
            state      <= STEP_IDLE;
            wait_cnt   <= '0;
            load_o     <= 1'b0;
            step_ack_o <= 1'b0;
        end
        else
        begin
            case (state)
                STEP_IDLE:
                begin
                    wait_cnt <= '0;
                    if (step_req_i)
                        state <= STEP_DIFF;
                end
                STEP_DIFF:   state <= STEP_ADDEND;
                STEP_ADDEND: state <= STEP_NEWVAL;
                STEP_NEWVAL:
                begin
                    load_o <= 1'b1;     // one-cycle load
                    state  <= STEP_LOAD;
                end
                STEP_LOAD:
                begin
                    load_o <= 1'b0;
                    if (diff != '0)
                        state <= STEP_WAIT;
                    else
                    begin
                        step_ack_o <= 1'b1;     // line sits at the target
                        state      <= STEP_ACK;
                    end
                end
                STEP_WAIT:
                begin
                    wait_cnt <= wait_last ? '0 : wait_cnt + 1'b1;
                    if (wait_last)
                        state <= STEP_DIFF;
                end
                STEP_ACK:
                begin
                    if (!step_req_i)
                    begin
                        step_ack_o <= 1'b0;
                        state      <= STEP_IDLE;
                    end
                end
                default: state <= STEP_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/iodelay_types_pkg.sv ====
package iodelay_types_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    typedef logic [8:0] delay_t;    // tap value of the delay line
    typedef logic [3:0] addend_t;   // size of one step

    //////////////////////////////
    // register layouts
    //////////////////////////////

    // host control word
    typedef struct packed
    {
        logic                  trig;      // rising edge starts a command
        iodelay_fsm_pkg::cmd_e cmd;
        logic [2:0]            reserved;
        delay_t                target;    // requested tap for an update
    } ctrl_reg_t;

    // status word back to the host
    typedef struct packed
    {
        logic       done;
        logic       error;      // tied low
        logic       modified;   // sticky since reset
        logic [3:0] reserved;
        delay_t     delay;      // last delay read back
    } status_reg_t;

    // strobes into the delay line
    typedef struct packed
    {
        logic load;
        logic ce;
        logic inc;
    } dly_strobe_t;

endpackage

// ==== verification/iodelay_lane_ctrl_assertions.sv ====
`timescale 1ns/1ps

module iodelay_lane_ctrl_assertions
(
    input logic                           riu_clk,
    input logic                           rst_riu,
    input iodelay_types_pkg::dly_strobe_t strobe_i,
    input logic                           en_vtc_i,
    input logic                           step_req_i,
    input logic                           step_ack_i,
    input iodelay_fsm_pkg::seq_state_e    seq_state_i
);
    import iodelay_types_pkg::*;
    import iodelay_fsm_pkg::*;

    int unsigned fail_count = 0;    // read by the testbench at the end

    // no strobe while compensation runs
    a_strobe_vtc: assert property (@(posedge riu_clk) disable iff (rst_riu)
        (strobe_i.load || strobe_i.ce) |-> !en_vtc_i)
        else begin $error("load or ce while en_vtc is high"); fail_count++; end

    a_load_once: assert property (@(posedge riu_clk) disable iff (rst_riu)
        strobe_i.load |=> !strobe_i.load)
        else begin $error("load longer than one cycle"); fail_count++; end

    a_ce_once: assert property (@(posedge riu_clk) disable iff (rst_riu)
        strobe_i.ce |=> !strobe_i.ce)
        else begin $error("ce longer than one cycle"); fail_count++; end

    a_ack_req: assert property (@(posedge riu_clk) disable iff (rst_riu)
        $rose(step_ack_i) |-> step_req_i)
        else begin $error("step_ack rose without step_req"); fail_count++; end

    // step engine loads only while the sequencer waits on it
    a_load_update: assert property (@(posedge riu_clk) disable iff (rst_riu)
        strobe_i.load |-> (seq_state_i == SEQ_UPDATE))
        else begin $error("load outside an update"); fail_count++; end

endmodule

bind iodelay_lane_ctrl iodelay_lane_ctrl_assertions u_assert
(
    .riu_clk     (riu_clk),
    .rst_riu     (rst_riu),
    .strobe_i    (strobe_o),
    .en_vtc_i    (en_vtc_o),
    .step_req_i  (step_req),
    .step_ack_i  (step_ack),
    .seq_state_i (u_seq.state)
);

// ==== verification/iodelay_trace.txt ====
// init_delay cmd target stall exp_delay exp_modified (hex)
// a first column of ffff ends the trace
020 0 000 0 020 0
0a5 5 1ff 3 0a5 0
040 1 000 0 041 1
041 2 000 2 040 1
100 3 130 0 130 1
130 3 12d 4 12d 1
055 3 055 0 055 1
1fe 2 000 1 1fd 1
001 1 000 0 002 1
0c8 3 050 6 050 1
050 0 000 0 050 1
1f0 3 1f7 2 1f7 1
010 3 019 a 019 1
ffff 0 0 0 0 0

// ==== verification/tb_iodelay_lane_ctrl.sv ====
`timescale 1ns/1ps

module tb_iodelay_lane_ctrl;
    import iodelay_types_pkg::*;
    import iodelay_fsm_pkg::*;

    localparam int SETTLE_CYCLES    = 10;
    localparam int LOAD_WAIT_CYCLES = 5;
    localparam int MAX_STEP         = 8;
    localparam int FIELDS           = 6;        // words per trace line
    localparam int MAX_CMDS         = 32;
    localparam logic [15:0] END_MARK = 16'hffff;

    logic        riu_clk;
    logic        rst_riu;
    ctrl_reg_t   ctrl_reg_i;
    logic        vtc_rdy_i;
    delay_t      cntvalue_o;
    dly_strobe_t strobe_o;
    logic        en_vtc_o;
    logic        rst_ctrl_reg_o;
    status_reg_t status_o;

    // delay line model
    delay_t      line_dly = '0;
    logic        preset_en;
    delay_t      preset_val;

    logic [15:0] trace_mem [0:MAX_CMDS*FIELDS-1];
    int          n_cmds = 0;
    int          idx;
    logic [31:0] rng_state = 32'd53;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          total_errors;

    // seen by the strobe monitor during one command
    dly_strobe_t strobe_or;
    int          ce_pulses = 0;
    int          load_taps;

    iodelay_lane_ctrl #(
        .SETTLE_CYCLES    (SETTLE_CYCLES),
        .LOAD_WAIT_CYCLES (LOAD_WAIT_CYCLES),
        .MAX_STEP         (MAX_STEP)
    ) UUT (
        .riu_clk        (riu_clk),
        .rst_riu        (rst_riu),
        .ctrl_reg_i     (ctrl_reg_i),
        .cntvalue_i     (line_dly),
        .vtc_rdy_i      (vtc_rdy_i),
        .cntvalue_o     (cntvalue_o),
        .strobe_o       (strobe_o),
        .en_vtc_o       (en_vtc_o),
        .rst_ctrl_reg_o (rst_ctrl_reg_o),
        .status_o       (status_o)
    );

    initial
    begin
        riu_clk = 1'b0;
        forever #50 riu_clk = ~riu_clk;
    end

    always @(posedge riu_clk)
    begin
        if (preset_en)
            line_dly <= preset_val;         // initial tap from the trace
        else if (strobe_o.load)
            line_dly <= cntvalue_o;
        else if (strobe_o.ce)
            line_dly <= strobe_o.inc ? line_dly + 1'b1 : line_dly - 1'b1;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic compare_delay(input string name, input delay_t exp, input delay_t act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_status(input string name, input status_reg_t exp,
                                  input status_reg_t act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_strobe(input string name, input dly_strobe_t exp,
                                  input dly_strobe_t act);
        checks++;
        if (act !== exp)
        begin
            value_errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // strobe monitor, every load step is checked against the line just before it
    initial
    begin
        forever
        begin
            @(negedge riu_clk);
            strobe_or = strobe_or | strobe_o;
            if (strobe_o.ce)
                ce_pulses++;
            if (strobe_o.load)
            begin
                load_taps = int'(cntvalue_o) - int'(line_dly);
                if (load_taps < 0)
                    load_taps = -load_taps;
                checks++;
                if (load_taps > MAX_STEP)
                begin
                    value_errors++;
                    $display("Error load step: expected at most %0d taps, actual %0d",
                             MAX_STEP, load_taps);
                end
            end
        end
    end

    //////////////////////////////
    // one trace line
    //////////////////////////////

    task automatic run_command(input int n);
        delay_t      init_dly;
        logic [2:0]  code;
        delay_t      target;
        int          stall;
        delay_t      exp_dly;
        status_reg_t exp_status;
        dly_strobe_t exp_strobe;
        string       name;

        init_dly   = delay_t'(trace_mem[n*FIELDS+0]);
        code       = trace_mem[n*FIELDS+1][2:0];
        target     = delay_t'(trace_mem[n*FIELDS+2]);
        stall      = int'(trace_mem[n*FIELDS+3]);
        exp_dly    = delay_t'(trace_mem[n*FIELDS+4]);
        exp_status = '0;
        exp_status.done     = 1'b1;
        exp_status.modified = trace_mem[n*FIELDS+5][0];
        exp_status.delay    = exp_dly;
        name       = $sformatf("cmd %0d code %0d", n, code);

        preset_val = init_dly;
        preset_en  = 1'b1;
        @(negedge riu_clk);
        preset_en  = 1'b0;
        rng_state  = xorshift32(rng_state);
        repeat (int'(rng_state % 7) + 1) @(negedge riu_clk);   // idle gap

        strobe_or  = '0;
        ce_pulses  = 0;
        ctrl_reg_i = {1'b1, code, 3'b000, target};
        if (stall > 0)
            vtc_rdy_i = 1'b0;
        for (int i = 0; i < stall; i++)
        begin
            @(negedge riu_clk);
            if (!en_vtc_o)
            begin
                other_errors++;
                $display("%s: en_vtc_o dropped before compensation was ready", name);
            end
            compare_strobe({name, " stall strobe"}, '0, strobe_o);
        end
        vtc_rdy_i = 1'b1;

        while (en_vtc_o)
            @(negedge riu_clk);
        while (!rst_ctrl_reg_o)
            @(negedge riu_clk);
        if (en_vtc_o)
        begin
            other_errors++;
            $display("%s: register clear came while en_vtc_o was high", name);
        end
        ctrl_reg_i.trig = 1'b0;       // host clears trig on register clear

        while (!status_o.done)
            @(negedge riu_clk);
        compare_status(name, exp_status, status_o);
        compare_delay({name, " line"}, exp_dly, line_dly);
        compare_delay({name, " readback"}, line_dly, status_o.delay);

        while (!en_vtc_o)
            @(negedge riu_clk);
        if (rst_ctrl_reg_o)
        begin
            other_errors++;
            $display("%s: register clear still high after en_vtc_o returned", name);
        end

        exp_strobe = '0;
        if (code == CMD_INC || code == CMD_DEC)
        begin
            exp_strobe.ce  = 1'b1;
            exp_strobe.inc = (code == CMD_INC);
            if (ce_pulses != 1)
            begin
                other_errors++;
                $display("%s: %0d ce pulses instead of exactly one", name, ce_pulses);
            end
        end
        else if (code == CMD_UPDATE)
            exp_strobe.load = 1'b1;
        compare_strobe({name, " strobes"}, exp_strobe, strobe_or);
    endtask

    //////////////////////////////
    // main
    //////////////////////////////

    initial
    begin
        rst_riu    = 1'b1;
        ctrl_reg_i = '0;
        vtc_rdy_i  = 1'b1;
        preset_en  = 1'b0;
        preset_val = '0;
        strobe_or  = '0;

        $readmemh("verification/iodelay_trace.txt", trace_mem);
        idx = 0;
        while (idx < MAX_CMDS && trace_mem[idx*FIELDS] !== END_MARK)
            idx++;
        if (idx > 0 && idx < MAX_CMDS)
            n_cmds = idx;
        else
        begin
            other_errors++;
            $display("trace file could not be read or holds no command");
        end

        repeat (8) @(posedge riu_clk);
        @(negedge riu_clk);
        rst_riu = 1'b0;

        @(negedge riu_clk);
        if (!en_vtc_o)
        begin
            other_errors++;
            $display("en_vtc_o is low after reset");
        end
        compare_strobe("reset strobe", '0, strobe_o);
        compare_status("reset status", '0, status_o);

        for (int i = 0; i < n_cmds; i++)
            run_command(i);
        repeat (4) @(negedge riu_clk);

        total_errors = value_errors + other_errors + UUT.u_assert.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, UUT.u_assert.fail_count);
        if (total_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (n_cmds > 0);
        repeat (n_cmds * 400) @(posedge riu_clk);
        $display("run timed out after %0d clock cycles", n_cmds * 400);
        $display("Something failed");
        $finish;
    end

endmodule
